// ==== source/noc_switch_pkg.sv ====
`default_nettype none

package noc_switch_pkg;

  localparam int MAX_INPUTS  = 8;
  localparam int SRC_ID_W    = 3;
  localparam int PAYLOAD_W   = 16;
  localparam int NUM_OUTPUTS = 2;
  localparam int APB_ADDR_W  = 8;
  localparam int APB_DATA_W  = 32;

  // constant returned by the id register
  localparam logic [APB_DATA_W-1:0] REG_ID_VALUE = 32'h5357_0001;

  typedef struct packed {
    logic                 dest;
    logic [SRC_ID_W-1:0]  src;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // register map, byte addresses
  typedef enum logic [APB_ADDR_W-1:0] {
    REG_CTRL = 8'h00,
    REG_CNT0 = 8'h04,
    REG_CNT1 = 8'h08,
    REG_ID   = 8'h0C
  } reg_addr_e;

endpackage

`default_nettype wire

// ==== source/rr_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NUM_INPUTS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [NUM_INPUTS-1:0]                req_i,
  input  logic                                 update_i,
  output logic [NUM_INPUTS-1:0]                grant_o,
  output logic [noc_switch_pkg::SRC_ID_W-1:0]  grant_id_o
);
  import noc_switch_pkg::*;

  localparam logic [SRC_ID_W-1:0] LAST_ID = SRC_ID_W'(NUM_INPUTS - 1);

  logic [SRC_ID_W-1:0]                 ptr_q;
  logic [2*NUM_INPUTS-1:0]             req_dbl;
  logic [NUM_INPUTS-1:0]               req_rot;
  logic [NUM_INPUTS-1:0]               sel_rot;
  logic [2*NUM_INPUTS-1:0]             sel_dbl;
  logic [SRC_ID_W-1:0][NUM_INPUTS-1:0] id_mask;

  // rotate right so the input holding priority lands on bit 0
  assign req_dbl = {req_i, req_i} >> ptr_q;
  assign req_rot = req_dbl[NUM_INPUTS-1:0];

  // keep only the lowest set bit, x & -x
  assign sel_rot = req_rot & (~req_rot + NUM_INPUTS'(1));

  // rotate left by the same amount to get back to input order
  assign sel_dbl = {sel_rot, sel_rot} << ptr_q;
  assign grant_o = sel_dbl[2*NUM_INPUTS-1:NUM_INPUTS];

  // id bit b is set for every input index that has bit b set
  for (genvar b = 0; b < SRC_ID_W; b++) begin : gen_id_bit
    for (genvar k = 0; k < NUM_INPUTS; k++) begin : gen_id_mask
      assign id_mask[b][k] = 1'((k >> b) & 1);
    end
    assign grant_id_o[b] = |(grant_o & id_mask[b]);
  end

  // after a win, the next input up gets priority
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (update_i) begin
      if (grant_id_o == LAST_ID) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_id_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/switch_output_port.sv ====
`default_nettype none
`timescale 1ns/1ps

module switch_output_port #(
  parameter int NUM_INPUTS = 4,
  parameter int PORT_IDX   = 0
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [NUM_INPUTS-1:0]                  in_valid_i,
  input  noc_switch_pkg::flit_t [NUM_INPUTS-1:0] in_flit_i,
  input  logic                                   enable_i,
  output logic [NUM_INPUTS-1:0]                  grant_o,
  output logic                                   accept_o,
  output logic                                   out_valid_o,
  output noc_switch_pkg::flit_t                  out_flit_o,
  input  logic                                   out_ready_i,
  output logic                                   delivered_o
);
  import noc_switch_pkg::*;

  logic [NUM_INPUTS-1:0] req;
  logic [SRC_ID_W-1:0]   grant_id;
  logic                  load;
  logic                  out_valid_q;
  flit_t                 sel_flit;
  flit_t                 out_flit_q;

  // only valid inputs whose flit is addressed to this port compete
  always_comb begin
    for (int k = 0; k < NUM_INPUTS; k++) begin
      req[k] = in_valid_i[k] && (in_flit_i[k].dest == 1'(PORT_IDX));
    end
  end

  rr_arbiter #(
    .NUM_INPUTS (NUM_INPUTS)
  ) u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .update_i   (load),
    .grant_o    (grant_o),
    .grant_id_o (grant_id)
  );

  // register is free when empty or being drained this cycle
  assign accept_o = enable_i && (!out_valid_q || out_ready_i);

  // a transfer happens exactly when we accept and someone won
  assign load = accept_o && (|grant_o);

  always_comb begin
    sel_flit = '0;
    for (int k = 0; k < NUM_INPUTS; k++) begin
      if (grant_id == SRC_ID_W'(k)) begin
        sel_flit = in_flit_i[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_flit_q <= sel_flit;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

  // one pulse per completed output handshake
  assign delivered_o = out_valid_q && out_ready_i;

endmodule

`default_nettype wire

// ==== source/input_grant_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

module input_grant_merge #(
  parameter int NUM_INPUTS = 4
) (
  input  logic [NUM_INPUTS-1:0] grant0_i,
  input  logic [NUM_INPUTS-1:0] grant1_i,
  input  logic                  accept0_i,
  input  logic                  accept1_i,
  output logic [NUM_INPUTS-1:0] in_ready_o
);

  logic [NUM_INPUTS-1:0] claim0;
  logic [NUM_INPUTS-1:0] claim1;
  logic [NUM_INPUTS-1:0] claim_any;
  logic [NUM_INPUTS-1:0] claim_both;

  // a grant only counts when its port can take the flit
  assign claim0 = grant0_i & {NUM_INPUTS{accept0_i}};
  assign claim1 = grant1_i & {NUM_INPUTS{accept1_i}};

  assign claim_any  = claim0 | claim1;
  assign claim_both = claim0 & claim1;

  // destination filtering means both ports should never claim one input,
  // but if they did the input would be popped once and land in two places
  assign in_ready_o = claim_any & ~claim_both;

endmodule

`default_nettype wire

// ==== source/switch_apb_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module switch_apb_regs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  noc_switch_pkg::apb_req_t               apb_req_i,
  output noc_switch_pkg::apb_rsp_t               apb_rsp_o,
  input  logic [noc_switch_pkg::NUM_OUTPUTS-1:0] delivered_i,
  output logic [noc_switch_pkg::NUM_OUTPUTS-1:0] port_enable_o
);
  import noc_switch_pkg::*;

  reg_addr_e              addr;
  logic                   access;
  logic                   addr_hit;
  logic                   slv_err;
  logic                   wr_en;
  logic [APB_DATA_W-1:0]  rdata;
  logic [NUM_OUTPUTS-1:0] ctrl_q;
  logic [NUM_OUTPUTS-1:0] cnt_clr;
  logic [APB_DATA_W-1:0]  cnt_q [NUM_OUTPUTS];

  // access phase, pready is tied high so this is always the last cycle
  assign access = apb_req_i.psel && apb_req_i.penable;
  assign addr   = reg_addr_e'(apb_req_i.paddr);

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (addr)
      REG_CTRL: rdata = {{(APB_DATA_W-NUM_OUTPUTS){1'b0}}, ctrl_q};
      REG_CNT0: rdata = cnt_q[0];
      REG_CNT1: rdata = cnt_q[1];
      REG_ID:   rdata = REG_ID_VALUE;
      default:  addr_hit = 1'b0;
    endcase
  end

  // unmapped address or write to the read-only id
  assign slv_err = access && (!addr_hit || (apb_req_i.pwrite && addr == REG_ID));

  // faulting writes do not touch any register
  assign wr_en = access && apb_req_i.pwrite && !slv_err;

  assign cnt_clr[0] = wr_en && (addr == REG_CNT0);
  assign cnt_clr[1] = wr_en && (addr == REG_CNT1);

  // both ports come out of reset enabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '1;
    end else if (wr_en && (addr == REG_CTRL)) begin
      ctrl_q <= apb_req_i.pwdata[NUM_OUTPUTS-1:0];
    end
  end

  // delivered-flit counters, a clear wins over a same-cycle increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < NUM_OUTPUTS; p++) begin
        cnt_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NUM_OUTPUTS; p++) begin
        if (cnt_clr[p]) begin
          cnt_q[p] <= '0;
        end else if (delivered_i[p]) begin
          cnt_q[p] <= cnt_q[p] + 32'd1;
        end
      end
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = slv_err;
    if (access && !apb_req_i.pwrite) begin
      apb_rsp_o.prdata = rdata;
    end
  end

  assign port_enable_o = ctrl_q;

endmodule

`default_nettype wire

// ==== source/noc_switch_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module noc_switch_top #(
  parameter int NUM_INPUTS = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [NUM_INPUTS-1:0]                                  in_valid_i,
  input  noc_switch_pkg::flit_t [NUM_INPUTS-1:0]                 in_flit_i,
  output logic [NUM_INPUTS-1:0]                                  in_ready_o,
  output logic [noc_switch_pkg::NUM_OUTPUTS-1:0]                 out_valid_o,
  output noc_switch_pkg::flit_t [noc_switch_pkg::NUM_OUTPUTS-1:0] out_flit_o,
  input  logic [noc_switch_pkg::NUM_OUTPUTS-1:0]                 out_ready_i,
  input  noc_switch_pkg::apb_req_t                               apb_req_i,
  output noc_switch_pkg::apb_rsp_t                               apb_rsp_o
);
  import noc_switch_pkg::*;

  logic [NUM_INPUTS-1:0]  grant0;
  logic [NUM_INPUTS-1:0]  grant1;
  logic                   accept0;
  logic                   accept1;
  logic [NUM_OUTPUTS-1:0] port_enable;
  logic [NUM_OUTPUTS-1:0] delivered;

  switch_output_port #(
    .NUM_INPUTS (NUM_INPUTS),
    .PORT_IDX   (0)
  ) u_port0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_flit_i   (in_flit_i),
    .enable_i    (port_enable[0]),
    .grant_o     (grant0),
    .accept_o    (accept0),
    .out_valid_o (out_valid_o[0]),
    .out_flit_o  (out_flit_o[0]),
    .out_ready_i (out_ready_i[0]),
    .delivered_o (delivered[0])
  );

  switch_output_port #(
    .NUM_INPUTS (NUM_INPUTS),
    .PORT_IDX   (1)
  ) u_port1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_flit_i   (in_flit_i),
    .enable_i    (port_enable[1]),
    .grant_o     (grant1),
    .accept_o    (accept1),
    .out_valid_o (out_valid_o[1]),
    .out_flit_o  (out_flit_o[1]),
    .out_ready_i (out_ready_i[1]),
    .delivered_o (delivered[1])
  );

  // per-input ready from the two ports' grants
  input_grant_merge #(
    .NUM_INPUTS (NUM_INPUTS)
  ) u_merge (
    .grant0_i   (grant0),
    .grant1_i   (grant1),
    .accept0_i  (accept0),
    .accept1_i  (accept1),
    .in_ready_o (in_ready_o)
  );

  switch_apb_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .delivered_i   (delivered),
    .port_enable_o (port_enable)
  );

endmodule

`default_nettype wire

// ==== verification/noc_switch_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module noc_switch_tb;
  import noc_switch_pkg::*;

  localparam int NUM_INPUTS  = 4;
  localparam int NUM_ENTRIES = 25;
  localparam int CYCLE_LIMIT = 20 * NUM_ENTRIES + 100;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } apb_op_e;

  // one table row holds the traffic offered plus an optional register access
  typedef struct packed {
    logic [NUM_INPUTS-1:0]  valid_mask;
    logic [NUM_INPUTS-1:0]  dest;
    logic [2:0]             burst;
    logic [NUM_OUTPUTS-1:0] out_ready;
    apb_op_e                op;
    logic [APB_ADDR_W-1:0]  addr;
    logic [APB_DATA_W-1:0]  wdata;
    logic                   exp_err;
  } stim_t;

  logic                           clk;
  logic                           rst_n;
  logic [NUM_INPUTS-1:0]          in_valid;
  flit_t [NUM_INPUTS-1:0]         in_flit;
  logic [NUM_INPUTS-1:0]          in_ready;
  logic [NUM_OUTPUTS-1:0]         out_valid;
  flit_t [NUM_OUTPUTS-1:0]        out_flit;
  logic [NUM_OUTPUTS-1:0]         out_ready;
  apb_req_t                       apb_req;
  apb_rsp_t                       apb_rsp;

  stim_t                          table_q [NUM_ENTRIES];
  int                             table_len;
  int unsigned                    cycle_cnt;

  // reference model of the switch
  int                             ptr_m [NUM_OUTPUTS];
  flit_t                          sb_q [NUM_OUTPUTS][$];
  logic [NUM_OUTPUTS-1:0]         enable_m;
  logic [APB_DATA_W-1:0]          cnt_m [NUM_OUTPUTS];
  logic [NUM_INPUTS-1:0]          pend;
  logic [NUM_INPUTS-1:0]          dest_m;
  int                             left_m [NUM_INPUTS];
  logic                           quiet;

  noc_switch_top #(
    .NUM_INPUTS (NUM_INPUTS)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit),
    .out_ready_i (out_ready),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp)
  );

  always #4 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_failure($sformatf("Timeout after %0d cycles, traffic never settled", cycle_cnt));
    end
  end

  task automatic check_flit(input string name, input flit_t act, input flit_t exp);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_apb(input string name, input apb_rsp_t act, input apb_rsp_t exp,
                           input bit with_data);
    if ((with_data && act !== exp) || act.pready !== exp.pready ||
        act.pslverr !== exp.pslverr) begin
      report_failure($sformatf("Mismatch at time %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_ready(input string name, input logic [NUM_INPUTS-1:0] act,
                             input logic [NUM_INPUTS-1:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s expected %b, got %b",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_valid(input string name, input logic [NUM_OUTPUTS-1:0] act,
                             input logic [NUM_OUTPUTS-1:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: %s expected %b, got %b",
                               $time, name, exp, act));
    end
  endtask

  function automatic apb_rsp_t idle_response();
    apb_rsp_t rsp;
    rsp.prdata  = '0;
    rsp.pready  = 1'b1;
    rsp.pslverr = 1'b0;
    return rsp;
  endfunction

  // register contents as the address map defines them
  function automatic logic [APB_DATA_W-1:0] model_rdata(input logic [APB_ADDR_W-1:0] addr);
    case (addr)
      8'h00:   return {{(APB_DATA_W-NUM_OUTPUTS){1'b0}}, enable_m};
      8'h04:   return cnt_m[0];
      8'h08:   return cnt_m[1];
      8'h0C:   return 32'h5357_0001;
      default: return '0;
    endcase
  endfunction

  // idle senders with flits left offer a fresh one
  task automatic drive_inputs();
    for (int k = 0; k < NUM_INPUTS; k++) begin
      if (!pend[k] && left_m[k] > 0) begin
        in_flit[k].dest    = dest_m[k];
        in_flit[k].src     = SRC_ID_W'(k);
        in_flit[k].payload = PAYLOAD_W'($urandom);
        pend[k]            = 1'b1;
        left_m[k]          = left_m[k] - 1;
      end
    end
    in_valid = pend;
  endtask

  // runs one clock that starts and ends on a falling edge
  task automatic step_cycle(input apb_rsp_t apb_exp, input bit apb_data);
    logic [NUM_INPUTS-1:0]  ready_exp;
    logic [NUM_OUTPUTS-1:0] valid_exp;
    logic [NUM_OUTPUTS-1:0] load;
    int                     win [NUM_OUTPUTS];
    int                     idx;
    drive_inputs();
    #2;
    ready_exp = '0;
    for (int p = 0; p < NUM_OUTPUTS; p++) begin
      valid_exp[p] = (sb_q[p].size() > 0);
      win[p] = -1;
      // search upward from the input holding priority
      for (int i = 0; i < NUM_INPUTS; i++) begin
        idx = (ptr_m[p] + i) % NUM_INPUTS;
        if (win[p] < 0 && pend[idx] && in_flit[idx].dest == 1'(p)) begin
          win[p] = idx;
        end
      end
      load[p] = enable_m[p] && (!valid_exp[p] || out_ready[p]) && (win[p] >= 0);
      if (load[p]) begin
        ready_exp[win[p]] = 1'b1;
      end
    end
    check_valid("out_valid_o", out_valid, valid_exp);
    for (int p = 0; p < NUM_OUTPUTS; p++) begin
      if (valid_exp[p]) begin
        check_flit($sformatf("out_flit_o[%0d]", p), out_flit[p], sb_q[p][0]);
      end
    end
    check_ready("in_ready_o", in_ready, ready_exp);
    check_apb("apb_rsp_o", apb_rsp, apb_exp, apb_data);
    // model state after the coming rising edge
    quiet = 1'b1;
    for (int p = 0; p < NUM_OUTPUTS; p++) begin
      if (valid_exp[p] && out_ready[p]) begin
        void'(sb_q[p].pop_front());
        cnt_m[p] = cnt_m[p] + 32'd1;
        quiet = 1'b0;
      end
      if (load[p]) begin
        sb_q[p].push_back(in_flit[win[p]]);
        pend[win[p]] = 1'b0;
        ptr_m[p] = (win[p] + 1) % NUM_INPUTS;
        quiet = 1'b0;
      end
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic apb_transfer(input apb_op_e op, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata, input logic exp_err);
    apb_rsp_t exp_rsp;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = (op == OP_WRITE);
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    step_cycle(idle_response(), 1'b0);
    apb_req.penable = 1'b1;
    exp_rsp.prdata  = model_rdata(addr);
    exp_rsp.pready  = 1'b1;
    exp_rsp.pslverr = exp_err;
    step_cycle(exp_rsp, (op == OP_READ) && !exp_err);
    // a good write lands at the edge that ends the access phase
    if (op == OP_WRITE && !exp_err) begin
      case (addr)
        8'h00:   enable_m = wdata[NUM_OUTPUTS-1:0];
        8'h04:   cnt_m[0] = '0;
        8'h08:   cnt_m[1] = '0;
        default: ;
      endcase
    end
    apb_req = '0;
  endtask

  task automatic run_entry(input stim_t s);
    if (s.op != OP_NONE) begin
      apb_transfer(s.op, s.addr, s.wdata, s.exp_err);
    end
    out_ready = s.out_ready;
    for (int k = 0; k < NUM_INPUTS; k++) begin
      if (s.valid_mask[k]) begin
        dest_m[k] = s.dest[k];
        left_m[k] = left_m[k] + s.burst;
      end
    end
    // run until nothing can move any more
    quiet = 1'b0;
    while (!quiet) begin
      step_cycle(idle_response(), 1'b0);
    end
  endtask

  task automatic add_stim(input logic [NUM_INPUTS-1:0] mask, input logic [NUM_INPUTS-1:0] dest,
                          input logic [2:0] burst, input logic [NUM_OUTPUTS-1:0] rdy,
                          input apb_op_e op, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata, input logic err);
    stim_t s;
    s.valid_mask = mask;
    s.dest       = dest;
    s.burst      = burst;
    s.out_ready  = rdy;
    s.op         = op;
    s.addr       = addr;
    s.wdata      = wdata;
    s.exp_err    = err;
    table_q[table_len] = s;
    table_len = table_len + 1;
  endtask

  task automatic build_table();
    // each input alone to each port
    add_stim(4'b0001, 4'b0000, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0010, 4'b0010, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0100, 4'b0000, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b1000, 4'b1000, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0001, 4'b0001, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0010, 4'b0000, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0100, 4'b0100, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b1000, 4'b0000, 3'd1, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    // round-robin on port 0 with all four inputs and then with two dropped out
    add_stim(4'b1111, 4'b0000, 3'd2, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0101, 4'b0000, 3'd2, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    // both ports loaded together
    add_stim(4'b1111, 4'b1010, 3'd2, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    // port 0 stalled while port 1 keeps going and released afterwards
    add_stim(4'b1111, 4'b1100, 3'd2, 2'b10, OP_NONE, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_NONE, 8'h00, 32'h0, 1'b0);
    // counter reads and clearing one by a write
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h04, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h08, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_WRITE, 8'h04, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h04, 32'h0, 1'b0);
    // port 1 disabled while port 0 runs on and enabled again afterwards
    add_stim(4'b1111, 4'b1010, 3'd1, 2'b11, OP_WRITE, 8'h00, 32'h1, 1'b0);
    add_stim(4'b0001, 4'b0000, 3'd1, 2'b11, OP_READ, 8'h00, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_WRITE, 8'h00, 32'h3, 1'b0);
    // id constant and error responses
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h0C, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h10, 32'h0, 1'b1);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_WRITE, 8'h0C, 32'h1234, 1'b1);
    add_stim(4'b0011, 4'b0010, 3'd1, 2'b11, OP_WRITE, 8'h08, 32'h0, 1'b0);
    add_stim(4'b0000, 4'b0000, 3'd0, 2'b11, OP_READ, 8'h08, 32'h0, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h1491_5f8e));
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '1;
    apb_req   = '0;
    cycle_cnt = 0;
    table_len = 0;
    pend      = '0;
    dest_m    = '0;
    enable_m  = '1;
    quiet     = 1'b1;
    for (int p = 0; p < NUM_OUTPUTS; p++) begin
      ptr_m[p] = 0;
      cnt_m[p] = '0;
    end
    for (int k = 0; k < NUM_INPUTS; k++) begin
      left_m[k] = 0;
    end
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int e = 0; e < table_len; e++) begin
      run_entry(table_q[e]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/noc_switch_pkg.sv
source/rr_arbiter.sv
source/switch_output_port.sv
source/input_grant_merge.sv
source/switch_apb_regs.sv
source/noc_switch_top.sv
verification/noc_switch_tb.sv
